// ==== hdl/commit_pkg.sv ====
package commit_pkg;

    localparam int NUM_SLOTS = 2;
    localparam int INT_LINES = 6;

    typedef logic [31:0] word_t;

    typedef enum logic [3:0] {
        ALU      = 4'd0,
        LOAD     = 4'd1,
        STORE    = 4'd2,
        CACHE    = 4'd3,
        SYSCALL  = 4'd4,
        BREAK    = 4'd5,
        ERET     = 4'd6,
        RESERVED = 4'd7
    } op_t;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_t;

    // MIPS cause register ExcCode values
    typedef enum logic [4:0] {
        INT  = 5'd0,
        ADEL = 5'd4,
        ADES = 5'd5,
        SYS  = 5'd8,
        BP   = 5'd9,
        RI   = 5'd10,
        OV   = 5'd12
    } exc_code_t;

    typedef struct packed {
        logic       valid;
        word_t      pc;
        op_t        op;
        mem_size_t  size;
        logic       signed_load;
        word_t      result;
        word_t      store_data;
        logic [4:0] destreg;
        logic       regwrite;
        logic       overflow;
        logic [2:0] cache_funct;
    } exec_slot_t;

    typedef struct packed {
        exc_code_t code;
        word_t     epc;
        word_t     badvaddr;
    } exception_t;

endpackage

// ==== hdl/bus_pkg.sv ====
package bus_pkg;

    localparam int BUS_WIDTH = 32;
    localparam int SEL_WIDTH = BUS_WIDTH / 8;

    // base of the cache control window
    localparam logic [BUS_WIDTH-1:0] CACHE_WINDOW = 32'hfff0_0000;

    typedef struct packed {
        logic [BUS_WIDTH-1:0] adr;
        logic [BUS_WIDTH-1:0] dat_w;
        logic [SEL_WIDTH-1:0] sel;
        logic                 we;
    } wb_req_t;

    typedef struct packed {
        logic [BUS_WIDTH-1:0] dat_r;
        logic                 ack;
    } wb_resp_t;

endpackage

// ==== hdl/exception_check.sv ====
`timescale 1ns/1ps

module exception_check
(
    input  commit_pkg::exec_slot_t slot,
    input  logic                   kill,
    input  logic                   int_req,
    output logic                   exc_valid,
    output commit_pkg::exception_t exc
);

    logic active;
    logic is_load;
    logic is_store;
    logic misaligned;

    assign active   = slot.valid && !kill;
    assign is_load  = slot.op == commit_pkg::LOAD;
    assign is_store = slot.op == commit_pkg::STORE;

    // alignment rule by access size
    always_comb
    begin
        case (slot.size)
            commit_pkg::SIZE_HALF:
                misaligned = slot.result[0];
            commit_pkg::SIZE_WORD:
                misaligned = |slot.result[1:0];
            default:
                misaligned = 1'b0;
        endcase
    end

    always_comb
    begin
        exc_valid    = active;
        exc.code     = commit_pkg::INT;
        exc.epc      = slot.pc;
        exc.badvaddr = '0;

        // first match wins
        if (int_req)
            exc.code = commit_pkg::INT;
        else if (slot.op == commit_pkg::RESERVED)
            exc.code = commit_pkg::RI;
        else if (slot.op == commit_pkg::SYSCALL)
            exc.code = commit_pkg::SYS;
        else if (slot.op == commit_pkg::BREAK)
            exc.code = commit_pkg::BP;
        else if (slot.overflow)
            exc.code = commit_pkg::OV;
        else if (misaligned && (is_load || is_store))
        begin
            exc.code     = is_load ? commit_pkg::ADEL : commit_pkg::ADES;
            exc.badvaddr = slot.result;
        end
        else
            exc_valid = 1'b0;

        if (!active)
            exc_valid = 1'b0;
    end

endmodule

// ==== hdl/store_format.sv ====
`timescale 1ns/1ps

module store_format
(
    input  commit_pkg::exec_slot_t slot,
    output logic [3:0]             sel,
    output commit_pkg::word_t      dat_w
);

    logic [1:0] lane;

    assign lane = slot.result[1:0];

    always_comb
    begin
        case (slot.size)
            commit_pkg::SIZE_BYTE:
            begin
                sel   = 4'b0001 << lane;
                dat_w = {24'b0, slot.store_data[7:0]} << {lane, 3'b000};
            end
            commit_pkg::SIZE_HALF:
            begin
                // upper or lower half, bit 0 is checked elsewhere
                sel   = lane[1] ? 4'b1100 : 4'b0011;
                dat_w = {16'b0, slot.store_data[15:0]} << {lane[1], 4'b0000};
            end
            default:
            begin
                sel   = 4'b1111;
                dat_w = slot.store_data;
            end
        endcase
    end

endmodule

// ==== hdl/req_port.sv ====
`timescale 1ns/1ps

module req_port
(
    input  logic             clk,
    input  logic             arst_n,
    input  logic             need,
    input  bus_pkg::wb_req_t req_in,
    input  logic             retire,
    input  logic             grant,
    input  logic             ack,
    output logic             request,
    output bus_pkg::wb_req_t req_out,
    output logic             complete
);

    logic served;
    logic granted_ack;

    assign granted_ack = grant && ack;

    assign request  = need && !served;
    assign complete = !need || served || granted_ack;

    // nothing on the port once served
    assign req_out = request ? req_in : '0;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            served <= 1'b0;
        end
        else if (retire)
        begin
            served <= 1'b0;
        end
        else if (granted_ack)
        begin
            served <= 1'b1;
        end
    end

endmodule

// ==== hdl/wb_arbiter.sv ====
`timescale 1ns/1ps

module wb_arbiter
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              req_d,
    input  logic              req_c,
    input  bus_pkg::wb_req_t  d_req,
    input  bus_pkg::wb_req_t  c_req,
    output logic              grant_d,
    output logic              grant_c,
    output bus_pkg::wb_resp_t rsp,
    output logic              cyc,
    output logic              stb,
    output logic              we,
    output commit_pkg::word_t adr,
    output commit_pkg::word_t dat_w,
    output logic [3:0]        sel,
    input  commit_pkg::word_t dat_r,
    input  logic              ack
);

    logic             owner_d;
    logic             start;
    bus_pkg::wb_req_t held;

    // new cycle only from idle, so one dead cycle follows every ack
    assign start = !cyc && (req_d || req_c);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            cyc     <= 1'b0;
            owner_d <= 1'b0;
        end
        else if (cyc)
        begin
            if (ack)
                cyc <= 1'b0;
        end
        else if (start)
        begin
            cyc     <= 1'b1;
            owner_d <= req_d;
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
            held <= req_d ? d_req : c_req;
    end

    assign grant_d = cyc && owner_d;
    assign grant_c = cyc && !owner_d;

    assign stb   = cyc;
    assign we    = held.we;
    assign adr   = held.adr;
    assign dat_w = held.dat_w;
    assign sel   = held.sel;

    assign rsp.dat_r = dat_r;
    assign rsp.ack   = cyc && ack;

endmodule

// ==== hdl/exception_commit.sv ====
`timescale 1ns/1ps

module exception_commit
(
    input  commit_pkg::exec_slot_t [commit_pkg::NUM_SLOTS-1:0] in_slots,
    input  logic                                               int_req,
    output commit_pkg::exec_slot_t [commit_pkg::NUM_SLOTS-1:0] out_slots,
    output logic                                               exception_valid,
    output commit_pkg::exception_t                             exception_data,
    output logic                                               d_need,
    output bus_pkg::wb_req_t                                   d_req,
    output logic                                               c_need,
    output bus_pkg::wb_req_t                                   c_req
);

    logic [commit_pkg::NUM_SLOTS-1:0]       slot_kill;
    logic [commit_pkg::NUM_SLOTS-1:0]       slot_int;
    logic [commit_pkg::NUM_SLOTS-1:0]       slot_exc;
    commit_pkg::exception_t [commit_pkg::NUM_SLOTS-1:0] exc;
    logic [commit_pkg::NUM_SLOTS-1:0][3:0]  fmt_sel;
    commit_pkg::word_t [commit_pkg::NUM_SLOTS-1:0] fmt_dat;
    logic [commit_pkg::NUM_SLOTS-1:0]       is_mem;
    logic [commit_pkg::NUM_SLOTS-1:0]       is_cache;
    logic                                   d_pick;
    logic                                   c_pick;
    commit_pkg::word_t                      c_addr;

    // slot 1 is older, its exception or ERET flushes slot 0
    assign slot_kill[1] = 1'b0;
    assign slot_kill[0] = slot_exc[1] ||
                          (in_slots[1].valid && in_slots[1].op == commit_pkg::ERET);

    // interrupts are taken on the older slot only
    assign slot_int[1] = int_req;
    assign slot_int[0] = 1'b0;

    for (genvar i = 0; i < commit_pkg::NUM_SLOTS; i++)
    begin : g_slot
        exception_check exception_check_i
        (
            .slot      (in_slots[i]),
            .kill      (slot_kill[i]),
            .int_req   (slot_int[i]),
            .exc_valid (slot_exc[i]),
            .exc       (exc[i])
        );

        store_format store_format_i
        (
            .slot  (in_slots[i]),
            .sel   (fmt_sel[i]),
            .dat_w (fmt_dat[i])
        );

        always_comb
        begin
            out_slots[i] = in_slots[i];
            if (slot_kill[i] || slot_exc[i])
            begin
                out_slots[i].valid    = 1'b0;
                out_slots[i].regwrite = 1'b0;
            end
        end

        assign is_mem[i]   = out_slots[i].valid &&
                             (out_slots[i].op == commit_pkg::LOAD ||
                              out_slots[i].op == commit_pkg::STORE);
        assign is_cache[i] = out_slots[i].valid && out_slots[i].op == commit_pkg::CACHE;
    end

    assign exception_valid = |slot_exc;
    assign exception_data  = slot_exc[1] ? exc[1] : exc[0];

    // older surviving slot first
    assign d_pick = is_mem[1];
    assign c_pick = is_cache[1];

    assign d_need      = |is_mem;
    assign d_req.adr   = {in_slots[d_pick].result[31:2], 2'b00};
    assign d_req.dat_w = fmt_dat[d_pick];
    assign d_req.sel   = fmt_sel[d_pick];
    assign d_req.we    = in_slots[d_pick].op == commit_pkg::STORE;

    assign c_addr = {16'b0, in_slots[c_pick].result[15:2], 2'b00};

    assign c_need      = |is_cache;
    assign c_req.adr   = bus_pkg::CACHE_WINDOW + c_addr;
    assign c_req.dat_w = {29'b0, in_slots[c_pick].cache_funct};
    assign c_req.sel   = '1;
    assign c_req.we    = 1'b1;

endmodule

// ==== hdl/commit_top.sv ====
`timescale 1ns/1ps

module commit_top
(
    input  logic                                               clk,
    input  logic                                               arst_n,
    input  commit_pkg::exec_slot_t [commit_pkg::NUM_SLOTS-1:0] in_slots,
    input  logic [commit_pkg::INT_LINES-1:0]                   int_pending,
    input  logic [commit_pkg::INT_LINES-1:0]                   int_enable,
    input  logic                                               int_ie,
    output commit_pkg::exec_slot_t [commit_pkg::NUM_SLOTS-1:0] out_slots,
    output logic                                               exception_valid,
    output commit_pkg::exception_t                             exception_data,
    output logic                                               done,
    output commit_pkg::word_t                                  load_data,
    output logic                                               cyc,
    output logic                                               stb,
    output logic                                               we,
    output commit_pkg::word_t                                  adr,
    output commit_pkg::word_t                                  dat_w,
    output logic [3:0]                                         sel,
    input  commit_pkg::word_t                                  dat_r,
    input  logic                                               ack
);

    logic              int_req;
    logic              d_need;
    logic              c_need;
    bus_pkg::wb_req_t  d_req;
    bus_pkg::wb_req_t  c_req;
    logic              req_d;
    logic              req_c;
    bus_pkg::wb_req_t  d_port_req;
    bus_pkg::wb_req_t  c_port_req;
    logic              complete_d;
    logic              complete_c;
    logic              grant_d;
    logic              grant_c;
    bus_pkg::wb_resp_t rsp;

    assign int_req = int_ie && |(int_pending & int_enable);
    assign done    = complete_d && complete_c;

    // read data captured on the ack edge of a load
    always_ff @(posedge clk)
    begin
        if (grant_d && rsp.ack && !we)
            load_data <= rsp.dat_r;
    end

    exception_commit exception_commit_i
    (
        .in_slots        (in_slots),
        .int_req         (int_req),
        .out_slots       (out_slots),
        .exception_valid (exception_valid),
        .exception_data  (exception_data),
        .d_need          (d_need),
        .d_req           (d_req),
        .c_need          (c_need),
        .c_req           (c_req)
    );

    req_port req_port_d
    (
        .clk      (clk),
        .arst_n   (arst_n),
        .need     (d_need),
        .req_in   (d_req),
        .retire   (done),
        .grant    (grant_d),
        .ack      (rsp.ack),
        .request  (req_d),
        .req_out  (d_port_req),
        .complete (complete_d)
    );

    req_port req_port_c
    (
        .clk      (clk),
        .arst_n   (arst_n),
        .need     (c_need),
        .req_in   (c_req),
        .retire   (done),
        .grant    (grant_c),
        .ack      (rsp.ack),
        .request  (req_c),
        .req_out  (c_port_req),
        .complete (complete_c)
    );

    wb_arbiter wb_arbiter_i
    (
        .clk     (clk),
        .arst_n  (arst_n),
        .req_d   (req_d),
        .req_c   (req_c),
        .d_req   (d_port_req),
        .c_req   (c_port_req),
        .grant_d (grant_d),
        .grant_c (grant_c),
        .rsp     (rsp),
        .cyc     (cyc),
        .stb     (stb),
        .we      (we),
        .adr     (adr),
        .dat_w   (dat_w),
        .sel     (sel),
        .dat_r   (dat_r),
        .ack     (ack)
    );

endmodule

// ==== tb/commit_top_tb.sv ====
`timescale 1ns/1ps

module commit_top_tb;

    logic                                               clk;
    logic                                               arst_n;
    commit_pkg::exec_slot_t [commit_pkg::NUM_SLOTS-1:0] in_slots;
    commit_pkg::exec_slot_t [commit_pkg::NUM_SLOTS-1:0] out_slots;
    logic [commit_pkg::INT_LINES-1:0]                   int_pending;
    logic [commit_pkg::INT_LINES-1:0]                   int_enable;
    logic                                               int_ie;
    logic                                               exception_valid;
    commit_pkg::exception_t                             exception_data;
    logic                                               done;
    commit_pkg::word_t                                  load_data;
    logic                                               cyc;
    logic                                               stb;
    logic                                               we;
    commit_pkg::word_t                                  adr;
    commit_pkg::word_t                                  dat_w;
    logic [3:0]                                         sel;
    commit_pkg::word_t                                  dat_r;
    logic                                               ack;

    // slave memory and wait-state generator
    logic [31:0] mem [0:255];
    logic [31:0] lfsr;
    logic [1:0]  waits;
    logic        busy;
    logic [7:0]  idx;
    int          i;
    int          b;
    logic [31:0] tx_adr [$];
    logic [7:0]  tx_ws [$];
    logic [31:0] tx_dat [$];

    // one bundle from the data file
    string       line;
    int          fd;
    int          nfields;
    int          n;
    int          cycles;
    int          k;
    logic [31:0] pc;
    logic [19:0] c1;
    logic [31:0] r1;
    logic [31:0] s1;
    logic [19:0] c0;
    logic [31:0] r0;
    logic [31:0] s0;
    logic [19:0] irq;
    logic [15:0] expf;
    logic [31:0] epc;
    logic [31:0] badv;
    logic [31:0] a1;
    logic [7:0]  w1;
    logic [31:0] d1;
    logic [31:0] a2;
    logic [7:0]  w2;
    logic [31:0] d2;
    logic [31:0] ld;
    logic [31:0] exp_adr [2];
    logic [7:0]  exp_ws [2];
    logic [31:0] exp_dat [2];
    int          bundles;
    int          mismatches;
    int          failures;
    logic        stop;

    commit_top commit_top_i
    (
        .clk             (clk),
        .arst_n          (arst_n),
        .in_slots        (in_slots),
        .int_pending     (int_pending),
        .int_enable      (int_enable),
        .int_ie          (int_ie),
        .out_slots       (out_slots),
        .exception_valid (exception_valid),
        .exception_data  (exception_data),
        .done            (done),
        .load_data       (load_data),
        .cyc             (cyc),
        .stb             (stb),
        .we              (we),
        .adr             (adr),
        .dat_w           (dat_w),
        .sel             (sel),
        .dat_r           (dat_r),
        .ack             (ack)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #4 clk = ~clk;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic commit_pkg::exec_slot_t make_slot(input logic [19:0] ctl,
                                                         input logic [31:0] slot_pc,
                                                         input logic [31:0] res,
                                                         input logic [31:0] sdat);
        commit_pkg::exec_slot_t s;
        s             = '0;
        s.valid       = ctl[16];
        s.pc          = slot_pc;
        s.op          = commit_pkg::op_t'(ctl[15:12]);
        s.size        = commit_pkg::mem_size_t'(ctl[9:8]);
        s.overflow    = ctl[4];
        s.cache_funct = ctl[2:0];
        s.result      = res;
        s.store_data  = sdat;
        s.destreg     = 5'd3;
        s.regwrite    = ctl[16];
        return s;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        mismatches++;
        $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, expected);
    endtask

    // Wishbone slave with 0 to 3 wait states per transaction
    initial
    begin
        ack   = 1'b0;
        dat_r = '0;
        busy  = 1'b0;
        waits = 2'd0;
        lfsr  = 32'ha51f;
        for (i = 0; i < 256; i++)
            mem[i[7:0]] = 32'h1000_0000 + {22'b0, i[7:0], 2'b00};
        forever
        begin
            @(posedge clk);
            #1;
            // bus is released for one cycle after every ack
            if (ack)
            begin
                if (cyc !== 1'b0)
                    report_mismatch("cyc", 32'(cyc), 32'd0);
                if (stb !== 1'b0)
                    report_mismatch("stb", 32'(stb), 32'd0);
            end
            ack = 1'b0;
            if (cyc === 1'b1 && stb !== 1'b1)
                report_mismatch("stb", 32'(stb), 32'd1);
            if (cyc && stb)
            begin
                if (!busy)
                begin
                    busy     = 1'b1;
                    lfsr     = lfsr_next(lfsr);
                    waits[0] = lfsr[0];
                    lfsr     = lfsr_next(lfsr);
                    waits[1] = lfsr[0];
                end
                if (waits == 2'd0)
                begin
                    busy  = 1'b0;
                    idx   = adr[9:2];
                    dat_r = mem[idx];
                    // cache window writes touch no memory
                    if (we && adr[31:20] != 12'hfff)
                        for (b = 0; b < 4; b++)
                            if (sel[b])
                                mem[idx][8*b +: 8] = dat_w[8*b +: 8];
                    tx_adr.push_back(adr);
                    tx_ws.push_back({3'b000, we, sel});
                    tx_dat.push_back(dat_w);
                    ack = 1'b1;
                end
                else
                    waits = waits - 2'd1;
            end
        end
    end

    task check_exception();
        if (exception_valid !== expf[12])
            report_mismatch("exception_valid", 32'(exception_valid), 32'(expf[12]));
        if (expf[12])
        begin
            if (exception_data.code !== expf[8:4])
                report_mismatch("exception_data.code", 32'(exception_data.code), 32'(expf[8:4]));
            if (exception_data.epc !== epc)
                report_mismatch("exception_data.epc", exception_data.epc, epc);
            if (exception_data.badvaddr !== badv)
                report_mismatch("exception_data.badvaddr", exception_data.badvaddr, badv);
        end
        if (out_slots[1].valid !== expf[1])
            report_mismatch("out_slots[1].valid", 32'(out_slots[1].valid), 32'(expf[1]));
        if (out_slots[0].valid !== expf[0])
            report_mismatch("out_slots[0].valid", 32'(out_slots[0].valid), 32'(expf[0]));
        if (out_slots[1].regwrite !== expf[1])
            report_mismatch("out_slots[1].regwrite", 32'(out_slots[1].regwrite), 32'(expf[1]));
        if (out_slots[0].regwrite !== expf[0])
            report_mismatch("out_slots[0].regwrite", 32'(out_slots[0].regwrite), 32'(expf[0]));
    endtask

    task wait_done();
        cycles = 0;
        while (done !== 1'b1 && cycles < 100)
        begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (done !== 1'b1)
        begin
            $display("timeout at %0t ns: done never rose for bundle %0d", $time, bundles);
            failures++;
            stop = 1'b1;
        end
        else if (n == 0 && cycles != 0)
        begin
            $display("bundle %0d has no bus request but took %0d cycles", bundles, cycles);
            failures++;
        end
        else if (n > 0 && ack !== 1'b1)
        begin
            $display("done for bundle %0d did not rise in the cycle of the last ack", bundles);
            failures++;
        end
        // done must not come before the last ack
        if (!stop && tx_adr.size() != n)
            report_mismatch("bus transaction count", tx_adr.size(), n);
    endtask

    task check_bus();
        exp_adr[0] = a1;
        exp_ws[0]  = w1;
        exp_dat[0] = d1;
        exp_adr[1] = a2;
        exp_ws[1]  = w2;
        exp_dat[1] = d2;
        for (k = 0; k < n && k < tx_adr.size(); k++)
        begin
            if (tx_adr[k] !== exp_adr[k])
                report_mismatch($sformatf("adr of transaction %0d", k), tx_adr[k], exp_adr[k]);
            if (tx_ws[k] !== exp_ws[k])
                report_mismatch($sformatf("{we, sel} of transaction %0d", k),
                                32'(tx_ws[k]), 32'(exp_ws[k]));
            if (exp_ws[k][4] && tx_dat[k] !== exp_dat[k])
                report_mismatch($sformatf("dat_w of transaction %0d", k), tx_dat[k], exp_dat[k]);
        end
        if (n > 0 && !w1[4] && load_data !== ld)
            report_mismatch("load_data", load_data, ld);
    endtask

    task run_bundle();
        nfields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                          pc, c1, r1, s1, c0, r0, s0, irq, expf, epc, badv,
                          n, a1, w1, d1, a2, w2, d2, ld);
        if (nfields != 19)
        begin
            $display("malformed line in test data: %s", line);
            failures++;
            stop = 1'b1;
        end
        else
        begin
            bundles++;
            tx_adr.delete();
            tx_ws.delete();
            tx_dat.delete();
            in_slots[1] = make_slot(c1, pc, r1, s1);
            in_slots[0] = make_slot(c0, pc + 32'd4, r0, s0);
            int_ie      = irq[16];
            int_pending = irq[13:8];
            int_enable  = irq[5:0];
            #1;
            check_exception();
            wait_done();
            if (!stop)
            begin
                @(posedge clk);
                #1;
                check_bus();
            end
        end
    endtask

    initial
    begin
        arst_n      = 1'b0;
        in_slots    = '0;
        int_pending = '0;
        int_enable  = '0;
        int_ie      = 1'b0;
        bundles     = 0;
        mismatches  = 0;
        failures    = 0;
        stop        = 1'b0;
        fd = $fopen("tb/commit_testdata.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open tb/commit_testdata.txt");
            failures++;
            stop = 1'b1;
        end
        repeat (2) @(posedge clk);
        #1 arst_n = 1'b1;
        #1;
        if (cyc !== 1'b0)
            report_mismatch("cyc", 32'(cyc), 32'd0);
        if (stb !== 1'b0)
            report_mismatch("stb", 32'(stb), 32'd0);
        @(posedge clk);
        #1;
        while (!stop && !$feof(fd))
        begin
            nfields = $fgets(line, fd);
            if (nfields > 0 && line.len() > 1 && line.substr(0, 0) != "#")
                run_bundle();
        end
        if (fd != 0)
            $fclose(fd);
        $display("bundles: %0d, mismatches: %0d, other errors: %0d",
                 bundles, mismatches, failures);
        if (mismatches == 0 && failures == 0 && bundles > 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== commit_top.f ====
hdl/commit_pkg.sv
hdl/bus_pkg.sv
hdl/exception_check.sv
hdl/store_format.sv
hdl/req_port.sv
hdl/wb_arbiter.sv
hdl/exception_commit.sv
hdl/commit_top.sv
tb/commit_top_tb.sv

// ==== Makefile ====
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module commit_top -f commit_top.f

sim:
	verilator --binary --timing --top-module commit_top_tb -f commit_top.f -o commit_top_sim
	./obj_dir/commit_top_sim | tee /dev/stderr | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

// ==== tb/commit_testdata.txt ====
# pc slot1(ctl result sdata) slot0(ctl result sdata) irq exp epc badv n adr1 ws1 dat1 adr2 ws2 dat2 ld
# ctl=valid,op,size,ovf,funct  irq=ie,pend(2),en(2)  exp=exc,code(2),outvalid  ws=we,sel
00400000 10000 11 0 10000 22 0 00000 0003 0 0 0 0 0 0 0 0 0 0
00400010 12200 40 cafef00d 10000 0 0 00000 0003 0 0 1 40 1f cafef00d 0 0 0 0
00400020 10000 0 0 11200 40 0 00000 0003 0 0 1 40 0f 0 0 0 0 cafef00d
00400030 12000 83 5a 10000 0 0 00000 0003 0 0 1 80 18 5a000000 0 0 0 0
00400040 10000 0 0 12100 86 1234 00000 0003 0 0 1 84 1c 12340000 0 0 0 0
00400050 11200 80 0 13003 1234 0 00000 0003 0 0 2 80 0f 0 fff01234 1f 3 5a000080
00400060 13005 1234abce 0 11200 84 0 00000 0003 0 0 2 84 0f 0 fff0abcc 1f 5 12340084
00400070 14000 0 0 12200 c0 deadbeef 00000 1080 00400070 0 0 0 0 0 0 0 0 0
00400080 16000 0 0 12200 c8 deadbeef 00000 0002 0 0 0 0 0 0 0 0 0 0
00400090 12200 c4 11223344 15000 0 0 00000 1092 00400094 0 1 c4 1f 11223344 0 0 0 0
004000a0 17000 0 0 10010 0 0 00000 10a0 004000a0 0 0 0 0 0 0 0 0 0
004000b0 10000 0 0 10000 0 0 10101 1000 004000b0 0 0 0 0 0 0 0 0 0
004000c0 10000 0 0 10000 0 0 10102 0003 0 0 0 0 0 0 0 0 0 0
004000d0 10000 0 0 10000 0 0 00101 0003 0 0 0 0 0 0 0 0 0 0
004000e0 11200 42 0 10000 0 0 00000 1040 004000e0 42 0 0 0 0 0 0 0 0
004000f0 10000 0 0 12100 45 5555 00000 1052 004000f4 45 0 0 0 0 0 0 0 0
00400100 10010 0 0 12200 c8 99 00000 10c0 00400100 0 0 0 0 0 0 0 0 0
00400110 11200 c0 0 10000 0 0 00000 0003 0 0 1 c0 0f 0 0 0 0 100000c0
00400120 00000 0 0 11200 c4 0 00000 0001 0 0 1 c4 0f 0 0 0 0 11223344
00400130 12100 102 beef 13001 10 0 00000 0003 0 0 2 100 1c beef0000 fff00010 1f 1 0
00400140 11200 100 0 10000 0 0 00000 0003 0 0 1 100 0f 0 0 0 0 beef0100
00400150 00000 0 0 00000 0 0 00000 0000 0 0 0 0 0 0 0 0 0 0
00400160 12000 1 ab 10000 0 0 00000 0003 0 0 1 0 12 0000ab00 0 0 0 0
00400170 10000 0 0 11200 0 0 00000 0003 0 0 1 0 0f 0 0 0 0 1000ab00
00400180 12000 1a2 3c 10000 0 0 00000 0003 0 0 1 1a0 14 003c0000 0 0 0 0
00400190 11200 1a0 0 13007 fffc 0 00000 0003 0 0 2 1a0 0f 0 fff0fffc 1f 7 103c01a0
